// File: logic/capi_pkg.sv
package capi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Host link MMIO types
  //////////////////////////////////////////////////////////////////////

  // Word address in 32-bit units, bit 0 is the most significant
  typedef logic [0:23] mmio_addr_t;

  // One doubleword of MMIO data
  typedef logic [0:63] mmio_data_t;

  // Request from the service layer, one per cycle at most
  typedef struct packed {
    logic       valid;
    logic       read;
    logic       doubleword;
    logic       cfg;
    mmio_addr_t address;
    logic       address_parity;
    mmio_data_t data;
    logic       data_parity;
  } mmio_req_t;

  // Response back to the service layer
  typedef struct packed {
    logic       ack;
    mmio_data_t data;
    logic       data_parity;
  } mmio_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Parity
  //////////////////////////////////////////////////////////////////////

  // Parity bit for a value of up to 64 bits
  // Odd mode makes the total count of ones odd
  function automatic logic parity_of(input mmio_data_t value, input logic odd);
    return (^value) ^ odd;
  endfunction

endpackage

// File: logic/afu_pkg.sv
package afu_pkg;

  //////////////////////////////////////////////////////////////////////
  // AFU descriptor
  //////////////////////////////////////////////////////////////////////

  // Descriptor as seen in config space, first field at doubleword 0
  typedef struct packed {
    logic [0:15]  num_ints_per_process;
    logic [0:15]  num_of_processes;
    logic [0:15]  num_of_afu_crs;
    logic [0:15]  req_prog_model;
    logic [0:191] reserved_1;
    logic [0:7]   reserved_2;
    logic [0:55]  afu_cr_len;
    logic [0:63]  afu_cr_offset;
    logic [0:5]   reserved_3;
    logic         psa_per_process_required;
    logic         psa_required;
    logic [0:55]  psa_length;
    logic [0:63]  psa_offset;
    logic [0:7]   reserved_4;
    logic [0:55]  afu_eb_len;
    logic [0:63]  afu_eb_offset;
  } afu_descriptor_t;

  localparam int DESC_WORDS = $bits(afu_descriptor_t) / 64;

  typedef logic [0:$bits(afu_descriptor_t)-1] desc_bits_t;

  // Doubleword index into config space, address bits 0 to 22
  typedef logic [0:22] dw_index_t;

  // Single process in dedicated mode, one config record
  localparam afu_descriptor_t afu_descriptor_c = '{
    num_ints_per_process:     16'h0000,
    num_of_processes:         16'h0001,
    num_of_afu_crs:           16'h0001,
    req_prog_model:           16'h8010,
    reserved_1:               '0,
    reserved_2:               8'h00,
    afu_cr_len:               56'h00_0000_0000_0001,
    afu_cr_offset:            64'h0000_0000_0000_0100,
    reserved_3:               6'b00_0000,
    psa_per_process_required: 1'b0,
    psa_required:             1'b1,
    psa_length:               56'h00_0000_0000_0000,
    psa_offset:               64'h0000_0000_0000_0000,
    reserved_4:               8'h00,
    afu_eb_len:               56'h00_0000_0000_0000,
    afu_eb_offset:            64'h0000_0000_0000_0000
  };

  // Zero past the end of the descriptor
  function automatic capi_pkg::mmio_data_t descriptor_word(input dw_index_t index);
    desc_bits_t  flat;
    int unsigned base;
    flat = afu_descriptor_c;
    base = index * 64;
    if (index >= dw_index_t'(DESC_WORDS)) begin
      return '0;
    end
    return flat[base +: 64];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // MMIO register map and error word
  //////////////////////////////////////////////////////////////////////

  typedef enum capi_pkg::mmio_addr_t {
    REG_1     = 24'h00_0000,
    REG_2     = 24'h00_0002,
    ERROR_REG = 24'h00_0004
  } reg_addr_e;

  typedef logic [0:63] err_word_t;
  typedef logic [0:7]  err_count_t;

  localparam int ERR_DATA_BIT    = 0;
  localparam int ERR_ADDR_BIT    = 1;
  localparam int ERR_COUNT_FIRST = 56;
  localparam int ERR_COUNT_BITS  = $bits(err_count_t);

endpackage

// File: logic/error_log.sv
`timescale 1ns/1ps

module error_log #(
  parameter int COUNT_WIDTH = 8
) (
  input  logic               clock,
  input  logic               rstn,
  input  logic [0:1]         parity_errors,
  input  logic               errors_ack,
  output afu_pkg::err_word_t errors
);

  localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

  logic [0:1]             flags;
  logic [COUNT_WIDTH-1:0] count;
  logic [0:1]             base_flags;
  logic [COUNT_WIDTH-1:0] base_count;

  // Clear on read
  // An error in the clear cycle starts the new log
  always_comb begin
    base_flags = errors_ack ? 2'b00 : flags;
    base_count = errors_ack ? '0 : count;
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      flags <= 2'b00;
      count <= '0;
    end else begin
      flags <= base_flags | parity_errors;
      if ((|parity_errors) && (base_count != COUNT_MAX)) begin
        count <= base_count + COUNT_WIDTH'(1);
      end else begin
        count <= base_count;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Error word as read over MMIO
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    errors = '0;
    errors[afu_pkg::ERR_DATA_BIT] = flags[0];
    errors[afu_pkg::ERR_ADDR_BIT] = flags[1];
    errors[afu_pkg::ERR_COUNT_FIRST +: afu_pkg::ERR_COUNT_BITS] = afu_pkg::err_count_t'(count);
  end

  // Count only grows between clears, so it never wraps
  a_count_saturates: assert property (@(posedge clock) disable iff (!rstn)
    !errors_ack |=> count >= $past(count));

endmodule

// File: logic/mmio.sv
`timescale 1ns/1ps

module mmio #(
  parameter bit ODD_PARITY   = 1'b1,
  parameter int COUNT_STEP_1 = 1,
  parameter int COUNT_STEP_2 = 3
) (
  input  logic                clock,
  input  logic                rstn,
  input  capi_pkg::mmio_req_t mmio_in,
  output capi_pkg::mmio_rsp_t mmio_out,
  input  afu_pkg::err_word_t  report_errors,
  output logic                report_errors_ack,
  output logic [0:1]          parity_errors
);

  // Decoded request as it travels down the pipe
  typedef struct packed {
    logic       valid;
    logic       cfg_read;
    logic       mmio_read;
    logic       mmio_write;
    logic       doubleword;
    logic       low_half;
    logic       sel_reg_1;
    logic       sel_reg_2;
    logic       sel_error;
    logic [0:1] perr;
  } ctl_t;

  logic                  s1_valid;
  capi_pkg::mmio_req_t   s1_req;
  logic                  s1_addr_err;
  logic                  s1_data_err;
  ctl_t                  s1_ctl;

  ctl_t                  s2_ctl;
  ctl_t                  s3_ctl;
  ctl_t                  s4_ctl;
  ctl_t                  s5_ctl;

  afu_pkg::dw_index_t    s2_index;
  capi_pkg::mmio_data_t  s2_data;
  capi_pkg::mmio_data_t  s3_data;
  capi_pkg::mmio_data_t  s4_data;
  capi_pkg::mmio_data_t  s5_data;
  logic                  s5_par;

  logic                  ack_q;
  capi_pkg::mmio_data_t  out_data_q;
  logic                  out_par_q;

  capi_pkg::mmio_data_t  counter_1;
  capi_pkg::mmio_data_t  counter_2;

  //////////////////////////////////////////////////////////////////////
  // Stage 1: capture the request
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= mmio_in.valid;
    end
  end

  always_ff @(posedge clock) begin
    s1_req <= mmio_in;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2: decode and parity check
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    s1_addr_err = capi_pkg::parity_of(capi_pkg::mmio_data_t'(s1_req.address), ODD_PARITY)
                  != s1_req.address_parity;
    // Data parity only means something on writes
    s1_data_err = !s1_req.read &&
                  (capi_pkg::parity_of(s1_req.data, ODD_PARITY) != s1_req.data_parity);

    s1_ctl            = '0;
    s1_ctl.valid      = s1_valid;
    s1_ctl.cfg_read   = s1_valid && s1_req.cfg && s1_req.read;
    s1_ctl.mmio_read  = s1_valid && !s1_req.cfg && s1_req.read;
    s1_ctl.mmio_write = s1_valid && !s1_req.cfg && !s1_req.read;
    s1_ctl.doubleword = s1_req.doubleword;
    s1_ctl.low_half   = s1_req.address[23];
    s1_ctl.sel_reg_1  = s1_req.address == afu_pkg::REG_1;
    s1_ctl.sel_reg_2  = s1_req.address == afu_pkg::REG_2;
    s1_ctl.sel_error  = s1_req.address == afu_pkg::ERROR_REG;
    s1_ctl.perr       = s1_valid ? {s1_data_err, s1_addr_err} : 2'b00;
  end

  // Control stages all shift together
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s2_ctl <= '0;
      s3_ctl <= '0;
      s4_ctl <= '0;
      s5_ctl <= '0;
    end else begin
      s2_ctl <= s1_ctl;
      s3_ctl <= s2_ctl;
      s4_ctl <= s3_ctl;
      s5_ctl <= s4_ctl;
    end
  end

  always_ff @(posedge clock) begin
    s2_index <= s1_req.address[0:22];
    s2_data  <= s1_req.data;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 3: register access
  //////////////////////////////////////////////////////////////////////

  // A read hands out the current value and then steps the counter
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      counter_1 <= '0;
      counter_2 <= '0;
    end else if (s2_ctl.mmio_write) begin
      if (s2_ctl.sel_reg_1) begin
        counter_1 <= s2_data;
      end
      if (s2_ctl.sel_reg_2) begin
        counter_2 <= s2_data;
      end
    end else if (s2_ctl.mmio_read) begin
      if (s2_ctl.sel_reg_1) begin
        counter_1 <= counter_1 + capi_pkg::mmio_data_t'(COUNT_STEP_1);
      end
      if (s2_ctl.sel_reg_2) begin
        counter_2 <= counter_2 + capi_pkg::mmio_data_t'(COUNT_STEP_2);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (s2_ctl.cfg_read) begin
      s3_data <= afu_pkg::descriptor_word(s2_index);
    end else if (s2_ctl.mmio_read && s2_ctl.sel_reg_1) begin
      s3_data <= counter_1;
    end else if (s2_ctl.mmio_read && s2_ctl.sel_reg_2) begin
      s3_data <= counter_2;
    end else begin
      s3_data <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stages 4 and 5: word select and parity
  //////////////////////////////////////////////////////////////////////

  // Single-word config reads get the chosen half on both halves
  always_ff @(posedge clock) begin
    if (s3_ctl.cfg_read && !s3_ctl.doubleword) begin
      if (s3_ctl.low_half) begin
        s4_data <= {s3_data[32:63], s3_data[32:63]};
      end else begin
        s4_data <= {s3_data[0:31], s3_data[0:31]};
      end
    end else begin
      s4_data <= s3_data;
    end
  end

  always_ff @(posedge clock) begin
    s5_data <= s4_data;
    s5_par  <= capi_pkg::parity_of(s4_data, ODD_PARITY);
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ack_q             <= 1'b0;
      parity_errors     <= 2'b00;
      report_errors_ack <= 1'b0;
    end else begin
      ack_q             <= s5_ctl.valid;
      parity_errors     <= s5_ctl.perr;
      report_errors_ack <= s5_ctl.mmio_read && s5_ctl.sel_error;
    end
  end

  always_ff @(posedge clock) begin
    out_data_q <= s5_data;
    out_par_q  <= s5_par;
  end

  // The error log is read in the ack cycle itself
  // so no error can land between the read and its clear
  assign mmio_out.ack         = ack_q;
  assign mmio_out.data        = report_errors_ack ? report_errors : out_data_q;
  assign mmio_out.data_parity = report_errors_ack ?
                                capi_pkg::parity_of(report_errors, ODD_PARITY) : out_par_q;

  // Ack answers a request six edges back, and every request gets one
  a_ack_has_request: assert property (@(posedge clock) disable iff (!rstn)
    mmio_out.ack |-> $past(mmio_in.valid, 6));

  a_request_gets_ack: assert property (@(posedge clock) disable iff (!rstn)
    mmio_in.valid |-> ##6 mmio_out.ack);

  // Log clear only in the ack of an MMIO read of ERROR_REG
  a_log_ack_in_ack: assert property (@(posedge clock) disable iff (!rstn)
    report_errors_ack |-> mmio_out.ack &&
      $past(mmio_in.valid && mmio_in.read && !mmio_in.cfg &&
            mmio_in.address == afu_pkg::ERROR_REG, 6));

endmodule

// File: logic/afu_top.sv
`timescale 1ns/1ps

module afu_top #(
  parameter bit ODD_PARITY   = 1'b1,
  parameter int COUNT_STEP_1 = 1,
  parameter int COUNT_STEP_2 = 3,
  parameter int COUNT_WIDTH  = 8
) (
  input  logic                clock,
  input  logic                rstn,
  input  capi_pkg::mmio_req_t mmio_in,
  output capi_pkg::mmio_rsp_t mmio_out,
  output logic [0:1]          mmio_errors
);

  afu_pkg::err_word_t report_errors;
  logic               report_errors_ack;

  mmio #(
    .ODD_PARITY   (ODD_PARITY),
    .COUNT_STEP_1 (COUNT_STEP_1),
    .COUNT_STEP_2 (COUNT_STEP_2)
  ) mmio0 (
    .clock             (clock),
    .rstn              (rstn),
    .mmio_in           (mmio_in),
    .mmio_out          (mmio_out),
    .report_errors     (report_errors),
    .report_errors_ack (report_errors_ack),
    .parity_errors     (mmio_errors)
  );

  // Per-response flags also feed the sticky log
  error_log #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) error_log0 (
    .clock         (clock),
    .rstn          (rstn),
    .parity_errors (mmio_errors),
    .errors_ack    (report_errors_ack),
    .errors        (report_errors)
  );

endmodule

// File: dv/afu_model.svh
`ifndef AFU_MODEL_SVH
`define AFU_MODEL_SVH

// Expected outcome of one request, queued at issue time
typedef struct packed {
  capi_pkg::mmio_rsp_t rsp;
  logic [0:1]          perr;
  afu_pkg::err_word_t  log;
  logic [31:0]         due;
} expect_t;

// Register and log state as the host should see it
capi_pkg::mmio_data_t reg_1_value = '0;
capi_pkg::mmio_data_t reg_2_value = '0;
logic [0:1]           log_flags   = 2'b00;
logic [7:0]           log_count   = '0;

//////////////////////////////////////////////////////////////////////
// Reference functions
//////////////////////////////////////////////////////////////////////

// Parity bit that makes the total count of ones odd
function automatic logic odd_parity(input capi_pkg::mmio_data_t value);
  return ~(^value);
endfunction

// Descriptor doublewords in field order, doubleword 0 first
function automatic capi_pkg::mmio_data_t descriptor_dw(input logic [0:22] index);
  afu_pkg::afu_descriptor_t d;
  d = afu_pkg::afu_descriptor_c;
  case (index)
    23'd0: return {d.num_ints_per_process, d.num_of_processes, d.num_of_afu_crs,
                   d.req_prog_model};
    23'd1: return d.reserved_1[0:63];
    23'd2: return d.reserved_1[64:127];
    23'd3: return d.reserved_1[128:191];
    23'd4: return {d.reserved_2, d.afu_cr_len};
    23'd5: return d.afu_cr_offset;
    23'd6: return {d.reserved_3, d.psa_per_process_required, d.psa_required,
                   d.psa_length};
    23'd7: return d.psa_offset;
    23'd8: return {d.reserved_4, d.afu_eb_len};
    23'd9: return d.afu_eb_offset;
    default: return '0;
  endcase
endfunction

function automatic afu_pkg::err_word_t log_word();
  afu_pkg::err_word_t w;
  w = '0;
  w[0] = log_flags[0];
  w[1] = log_flags[1];
  w[56:63] = log_count;
  return w;
endfunction

task automatic predict(input capi_pkg::mmio_req_t req, output expect_t exp);
  capi_pkg::mmio_data_t word;
  logic                 addr_bad;
  logic                 data_bad;
  addr_bad = odd_parity({40'd0, req.address}) != req.address_parity;
  data_bad = !req.read && (odd_parity(req.data) != req.data_parity);
  word = '0;
  exp = '0;
  // Log as it stands once all earlier responses are in
  exp.log = log_word();
  if (req.cfg && req.read) begin
    word = descriptor_dw(req.address[0:22]);
    // Single word reads repeat the chosen half
    if (!req.doubleword && req.address[23]) begin
      word = {word[32:63], word[32:63]};
    end else if (!req.doubleword) begin
      word = {word[0:31], word[0:31]};
    end
  end else if (req.read) begin
    if (req.address == afu_pkg::REG_1) begin
      word = reg_1_value;
      reg_1_value = reg_1_value + capi_pkg::mmio_data_t'(COUNT_STEP_1);
    end else if (req.address == afu_pkg::REG_2) begin
      word = reg_2_value;
      reg_2_value = reg_2_value + capi_pkg::mmio_data_t'(COUNT_STEP_2);
    end else if (req.address == afu_pkg::ERROR_REG) begin
      word = log_word();
      log_flags = 2'b00;
      log_count = '0;
    end
  end else if (!req.cfg) begin
    if (req.address == afu_pkg::REG_1) begin
      reg_1_value = req.data;
    end else if (req.address == afu_pkg::REG_2) begin
      reg_2_value = req.data;
    end
  end
  exp.rsp.ack = 1'b1;
  exp.rsp.data = word;
  exp.rsp.data_parity = odd_parity(word);
  exp.perr = {data_bad, addr_bad};
  // Own errors land after the clear of a log read
  if (data_bad || addr_bad) begin
    log_flags = log_flags | exp.perr;
    if (log_count != 8'hff) begin
      log_count = log_count + 8'd1;
    end
  end
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_rsp(input capi_pkg::mmio_rsp_t got, input capi_pkg::mmio_rsp_t exp);
  if (got.ack !== exp.ack) begin
    rsp_errors++;
    $display("MISMATCH mmio_out.ack got %h expected %h", got.ack, exp.ack);
  end
  if (got.data !== exp.data) begin
    rsp_errors++;
    $display("MISMATCH mmio_out.data got %h expected %h", got.data, exp.data);
  end
  if (got.data_parity !== exp.data_parity) begin
    rsp_errors++;
    $display("MISMATCH mmio_out.data_parity got %h expected %h",
             got.data_parity, exp.data_parity);
  end
endtask

task automatic check_errors(input logic [0:1] got, input logic [0:1] exp);
  if (got !== exp) begin
    flag_errors++;
    $display("MISMATCH mmio_errors got %h expected %h", got, exp);
  end
endtask

task automatic check_log(input afu_pkg::err_word_t got, input afu_pkg::err_word_t exp);
  if (got !== exp) begin
    log_errors++;
    $display("MISMATCH report_errors got %h expected %h", got, exp);
  end
endtask

`endif

// File: dv/tb_afu.sv
`timescale 1ns/1ps

module tb_afu;

  localparam bit          ODD_PARITY   = 1'b1;
  localparam int          COUNT_STEP_1 = 1;
  localparam int          COUNT_STEP_2 = 3;
  localparam int          COUNT_WIDTH  = 8;
  localparam int          WAIT_LIMIT   = 50;
  localparam int          STREAM_LEN   = 400;
  localparam logic [31:0] SEED         = 32'h1c3c_b6d7;

  logic                clock;
  logic                rstn;
  capi_pkg::mmio_req_t mmio_in;
  capi_pkg::mmio_rsp_t mmio_out;
  logic [0:1]          mmio_errors;

  int          rsp_errors      = 0;
  int          flag_errors     = 0;
  int          log_errors      = 0;
  int          protocol_errors = 0;
  int          timeouts        = 0;
  logic [31:0] cycle           = '0;
  logic [31:0] rng_state;

  `include "afu_model.svh"

  expect_t pending[$];

  afu_top #(
    .ODD_PARITY   (ODD_PARITY),
    .COUNT_STEP_1 (COUNT_STEP_1),
    .COUNT_STEP_2 (COUNT_STEP_2),
    .COUNT_WIDTH  (COUNT_WIDTH)
  ) dut0 (
    .clock       (clock),
    .rstn        (rstn),
    .mmio_in     (mmio_in),
    .mmio_out    (mmio_out),
    .mmio_errors (mmio_errors)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 32'd1;
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic roll(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  function automatic capi_pkg::mmio_req_t build_req(
    input logic read, input logic cfg, input logic dw, input capi_pkg::mmio_addr_t addr,
    input capi_pkg::mmio_data_t data, input logic bad_addr, input logic bad_data);
    capi_pkg::mmio_req_t req;
    req = '0;
    req.valid = 1'b1;
    req.read = read;
    req.cfg = cfg;
    req.doubleword = dw;
    req.address = addr;
    req.data = data;
    req.address_parity = odd_parity({40'd0, addr}) ^ bad_addr;
    req.data_parity = odd_parity(data) ^ bad_data;
    return req;
  endfunction

  // One request per cycle, expected result queued right away
  task automatic send(input capi_pkg::mmio_req_t req);
    expect_t exp;
    @(posedge clock);
    #1;
    mmio_in = req;
    predict(req, exp);
    exp.due = cycle + 32'd6;
    pending.push_back(exp);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      #1;
      mmio_in = '0;
    end
  endtask

  task automatic read_reg(input capi_pkg::mmio_addr_t addr, input logic bad_addr);
    send(build_req(1'b1, 1'b0, 1'b1, addr, '0, bad_addr, 1'b0));
  endtask

  task automatic write_reg(input capi_pkg::mmio_addr_t addr, input capi_pkg::mmio_data_t data,
                           input logic bad_addr, input logic bad_data);
    send(build_req(1'b0, 1'b0, 1'b1, addr, data, bad_addr, bad_data));
  endtask

  task automatic random_req(output capi_pkg::mmio_req_t req);
    logic [31:0]          r;
    logic [31:0]          c;
    logic [31:0]          hi;
    logic [31:0]          lo;
    logic                 cfg;
    logic                 read;
    capi_pkg::mmio_addr_t addr;
    roll(r);
    roll(c);
    roll(hi);
    roll(lo);
    cfg = r[3:0] < 4'd5;
    read = cfg ? (r[4] | r[5]) : r[6];
    if (cfg) begin
      addr = {19'd0, r[11:8], r[12]};
    end else begin
      case (r[15:13])
        3'd0, 3'd1: addr = afu_pkg::REG_1;
        3'd2, 3'd3: addr = afu_pkg::REG_2;
        3'd4:       addr = afu_pkg::ERROR_REG;
        3'd5:       addr = 24'h00_0001;
        3'd6:       addr = 24'h00_0006;
        default:    addr = {8'h01, r[31:16]};
      endcase
    end
    req = build_req(read, cfg, r[7], addr, {hi, lo}, c[3:0] == 4'd0, c[7:4] == 4'd0);
  endtask

  task automatic finish_report();
    $display("Errors: %0d response, %0d flag, %0d log, %0d protocol, %0d timeout",
             rsp_errors, flag_errors, log_errors, protocol_errors, timeouts);
    if (rsp_errors + flag_errors + log_errors + protocol_errors + timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////////////

  // The oldest request owns the cycle its response is due in
  always @(negedge clock) begin : monitor
    expect_t head;
    if (rstn) begin
      if (pending.size() != 0 && pending[0].due == cycle) begin
        head = pending.pop_front();
        check_rsp(mmio_out, head.rsp);
        check_errors(mmio_errors, head.perr);
        check_log(dut0.report_errors, head.log);
      end else begin
        if (mmio_out.ack !== 1'b0) begin
          protocol_errors++;
          $display("Ack is %b at cycle %0d with no response due", mmio_out.ack, cycle);
        end
        if (mmio_errors !== 2'b00) begin
          protocol_errors++;
          $display("Parity error flags raised outside an ack cycle at cycle %0d", cycle);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin : main
    capi_pkg::mmio_req_t req;
    logic [31:0]         hi;
    logic [31:0]         lo;
    int                  waited;
    mmio_in = '0;
    rstn = 1'b0;
    rng_state = SEED;
    repeat (2) @(posedge clock);
    #1;
    rstn = 1'b1;
    // Quiet link first
    idle(6);

    // Descriptor, whole doublewords and both halves
    for (int i = 0; i < 12; i++) begin
      send(build_req(1'b1, 1'b1, 1'b1, {23'(i), 1'b0}, '0, 1'b0, 1'b0));
      send(build_req(1'b1, 1'b1, 1'b0, {23'(i), 1'b0}, '0, 1'b0, 1'b0));
      send(build_req(1'b1, 1'b1, 1'b0, {23'(i), 1'b1}, '0, 1'b0, 1'b0));
    end
    idle(3);

    // Counters, unmapped words and config writes
    roll(hi);
    roll(lo);
    write_reg(afu_pkg::REG_1, {hi, lo}, 1'b0, 1'b0);
    repeat (3) read_reg(afu_pkg::REG_1, 1'b0);
    write_reg(afu_pkg::REG_2, {lo, hi}, 1'b0, 1'b0);
    repeat (3) read_reg(afu_pkg::REG_2, 1'b0);
    read_reg(24'h00_0001, 1'b0);
    read_reg(24'h00_0006, 1'b0);
    write_reg(24'h00_0003, {hi, hi}, 1'b0, 1'b0);
    write_reg(afu_pkg::ERROR_REG, {lo, lo}, 1'b0, 1'b0);
    send(build_req(1'b0, 1'b1, 1'b1, afu_pkg::REG_1, {lo, lo}, 1'b0, 1'b0));
    read_reg(afu_pkg::REG_1, 1'b0);
    read_reg(afu_pkg::REG_2, 1'b0);
    write_reg(afu_pkg::REG_1, 64'hffff_ffff_ffff_ffff, 1'b0, 1'b0);
    repeat (2) read_reg(afu_pkg::REG_1, 1'b0);
    idle(4);

    // Corrupted parity, then the log and its clear
    write_reg(afu_pkg::REG_1, {hi, lo}, 1'b0, 1'b1);
    read_reg(afu_pkg::REG_2, 1'b1);
    write_reg(24'h00_0100, {lo, hi}, 1'b1, 1'b1);
    read_reg(afu_pkg::ERROR_REG, 1'b0);
    read_reg(afu_pkg::ERROR_REG, 1'b0);
    read_reg(afu_pkg::ERROR_REG, 1'b1);
    read_reg(afu_pkg::ERROR_REG, 1'b0);
    idle(4);

    for (int n = 0; n < STREAM_LEN; n++) begin
      random_req(req);
      send(req);
    end
    idle(1);

    waited = 0;
    while (pending.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clock);
      waited++;
    end
    if (pending.size() != 0) begin
      timeouts++;
      $display("Timeout after %0d cycles with %0d responses still missing",
               waited, pending.size());
    end
    // Stray acks would show here
    idle(10);
    finish_report();
  end

endmodule

// File: tb.f
+incdir+dv
logic/capi_pkg.sv
logic/afu_pkg.sv
logic/error_log.sv
logic/mmio.sv
logic/afu_top.sv
dv/tb_afu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_afu -f tb.f -o tb_afu

output=$(./obj_dir/tb_afu)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
echo "simulation did not report a pass" >&2
exit 1
